/* rtl/lc3b_isa_pkg.sv */
`default_nettype none

package lc3b_isa_pkg;

  typedef logic [15:0] lc3b_word;  // data words and byte addresses.
  typedef logic [2:0] lc3b_reg;    // index into the eight general registers.
  typedef logic [2:0] lc3b_nzp;    // condition code, bit 2 is N and bit 0 is P.

  // Only the opcodes the core executes are named. Every other encoding is retired as a NOP.
  typedef enum logic [3:0] {
    op_br   = 4'b0000,
    op_add  = 4'b0001,
    op_and  = 4'b0101,
    op_ldr  = 4'b0110,
    op_str  = 4'b0111,
    op_not  = 4'b1001,
    op_trap = 4'b1111
  } lc3b_opcode;

  localparam lc3b_nzp nzp_n = 3'b100;  // negative result.
  localparam lc3b_nzp nzp_z = 3'b010;  // zero result, also the code after reset.
  localparam lc3b_nzp nzp_p = 3'b001;  // positive result.

  // ADD, AND and NOT read the word this way.
  typedef struct packed {
    lc3b_opcode opcode;
    lc3b_reg    dest;
    lc3b_reg    src1;
    logic       imm_flag;     // high selects imm5, low selects the register in field5[2:0].
    logic [4:0] field5;
  } lc3b_operate_view;

  // BR, LDR and STR read the word this way.
  typedef struct packed {
    lc3b_opcode opcode;
    logic [2:0] field3;       // nzp mask for BR, data register for LDR and STR.
    logic [8:0] field9;       // offset9 for BR, base register and offset6 for LDR and STR.
  } lc3b_mem_view;

  typedef union packed {
    lc3b_operate_view op;
    lc3b_mem_view     mb;
  } lc3b_instr;

  // condition code that a register write of this value produces.
  function automatic lc3b_nzp nzp_of(lc3b_word value);
    lc3b_nzp code;
    if (value[15]) begin
      code = nzp_n;
    end else if (value == 16'h0000) begin
      code = nzp_z;
    end else begin
      code = nzp_p;
    end
    return code;
  endfunction

endpackage

`default_nettype wire

/* rtl/lc3b_core_pkg.sv */
`default_nettype none

package lc3b_core_pkg;

  // address of the first instruction fetched after reset.
  localparam lc3b_isa_pkg::lc3b_word reset_pc = 16'h0000;

  // Fetch queue sizing. The depth must be a power of two so the pointers wrap on their own.
  localparam int unsigned queue_depth     = 4;
  localparam int unsigned queue_ptr_width = 2;

endpackage

`default_nettype wire

/* rtl/fetch_unit.sv */
`default_nettype none

module fetch_unit (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    instruction_response,
  input  lc3b_isa_pkg::lc3b_word  instr,
  input  logic                    push_ready,
  input  logic                    redirect,
  input  lc3b_isa_pkg::lc3b_word  redirect_pc,
  output logic                    instruction_request,
  output lc3b_isa_pkg::lc3b_word  instruction_address,
  output logic                    push_valid,
  output lc3b_isa_pkg::lc3b_word  push_pc,
  output lc3b_isa_pkg::lc3b_word  push_instr
);

  lc3b_isa_pkg::lc3b_word pc;          // next address to fetch.
  lc3b_isa_pkg::lc3b_word req_addr;    // address of the request on the port.
  logic                   pending;     // one instruction request is outstanding.
  logic                   discard;     // the outstanding request belongs to an abandoned path.
  logic                   hold_valid;
  lc3b_isa_pkg::lc3b_word hold_pc;
  lc3b_isa_pkg::lc3b_word hold_instr;
  logic                   push_fire;
  logic                   accept;
  logic                   start;

  assign push_fire = hold_valid && push_ready;
  assign accept    = pending && instruction_response && !discard && !redirect;  // keep the word.
  // a new request starts once the holding register is free or leaves this cycle.
  assign start     = !pending && !redirect && (!hold_valid || push_fire);

  assign instruction_request = pending;
  assign instruction_address = req_addr;  // stays put while the request is open.
  assign push_valid          = hold_valid;
  assign push_pc             = hold_pc;
  assign push_instr          = hold_instr;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc         <= lc3b_core_pkg::reset_pc;
      req_addr   <= lc3b_core_pkg::reset_pc;
      pending    <= 1'b0;
      discard    <= 1'b0;
      hold_valid <= 1'b0;
    end else begin
      if (redirect) begin
        pc <= redirect_pc;
      end else if (accept) begin
        pc <= pc + 16'd2;  // sequential fetch.
      end

      if (start) begin
        req_addr <= pc;
      end

      if (pending) begin
        if (instruction_response) begin
          pending <= 1'b0;
        end
      end else if (start) begin
        pending <= 1'b1;
      end

      if (pending && instruction_response) begin
        discard <= 1'b0;  // the stale word has come back and is dropped.
      end else if (redirect && pending) begin
        discard <= 1'b1;
      end

      if (redirect) begin
        hold_valid <= 1'b0;  // a held word is from the old path.
      end else if (accept) begin
        hold_valid <= 1'b1;
      end else if (push_fire) begin
        hold_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      hold_pc    <= req_addr;
      hold_instr <= instr;
    end
  end

endmodule

`default_nettype wire

/* rtl/fetch_queue.sv */
`default_nettype none

module fetch_queue (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    flush,
  input  logic                    push_valid,
  input  lc3b_isa_pkg::lc3b_word  push_pc,
  input  lc3b_isa_pkg::lc3b_word  push_instr,
  input  logic                    pop_ready,
  output logic                    push_ready,
  output logic                    pop_valid,
  output lc3b_isa_pkg::lc3b_word  pop_pc,
  output lc3b_isa_pkg::lc3b_word  pop_instr
);

  typedef logic [lc3b_core_pkg::queue_ptr_width-1:0] ptr_t;
  typedef logic [lc3b_core_pkg::queue_ptr_width:0] count_t;

  lc3b_isa_pkg::lc3b_word pc_mem    [lc3b_core_pkg::queue_depth];
  lc3b_isa_pkg::lc3b_word instr_mem [lc3b_core_pkg::queue_depth];
  ptr_t                   rd_ptr;
  ptr_t                   wr_ptr;
  count_t                 count;    // entries currently stored.
  logic                   push_fire;
  logic                   pop_fire;

  assign push_ready = count != count_t'(lc3b_core_pkg::queue_depth);
  assign pop_valid  = count != '0;  // no bypass, a new entry shows one cycle later.
  assign push_fire  = push_valid && push_ready;
  assign pop_fire   = pop_valid && pop_ready;

  assign pop_pc    = pc_mem[rd_ptr];
  assign pop_instr = instr_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      rd_ptr <= '0;  // flush wins over a push in the same cycle.
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr <= wr_ptr + ptr_t'(1);
      end
      if (pop_fire) begin
        rd_ptr <= rd_ptr + ptr_t'(1);
      end
      count <= count + count_t'(push_fire) - count_t'(pop_fire);
    end
  end

  always_ff @(posedge clk) begin
    if (push_fire && !flush) begin
      pc_mem[wr_ptr]    <= push_pc;
      instr_mem[wr_ptr] <= push_instr;
    end
  end

endmodule

`default_nettype wire

/* rtl/execute_unit.sv */
`default_nettype none

module execute_unit (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    pop_valid,
  input  lc3b_isa_pkg::lc3b_word  pop_pc,
  input  lc3b_isa_pkg::lc3b_word  pop_instr,
  input  logic                    data_response,
  input  lc3b_isa_pkg::lc3b_word  mem_rdata,
  output logic                    pop_ready,
  output logic                    redirect,
  output lc3b_isa_pkg::lc3b_word  redirect_pc,
  output logic                    data_request,
  output lc3b_isa_pkg::lc3b_word  mem_address,
  output logic                    write_enable,
  output lc3b_isa_pkg::lc3b_word  write_data,
  output logic                    halted
);

  lc3b_isa_pkg::lc3b_instr  ir;
  lc3b_isa_pkg::lc3b_opcode opcode;
  lc3b_isa_pkg::lc3b_word   regs [8];
  lc3b_isa_pkg::lc3b_nzp    nzp;
  logic                     mem_wait;   // with halted this forms the idle, memory and halt states.
  lc3b_isa_pkg::lc3b_reg    mem_dest;   // destination of the load in flight.
  logic                     pop_fire;
  lc3b_isa_pkg::lc3b_word   src1_value;
  lc3b_isa_pkg::lc3b_word   src2_value;
  lc3b_isa_pkg::lc3b_word   imm5_sext;
  lc3b_isa_pkg::lc3b_word   operand_b;
  lc3b_isa_pkg::lc3b_word   offset6_sext;
  lc3b_isa_pkg::lc3b_word   offset9_sext;
  lc3b_isa_pkg::lc3b_word   base_value;
  lc3b_isa_pkg::lc3b_word   alu_result;
  logic                     is_alu;
  logic                     is_mem;
  logic                     wr_en;
  lc3b_isa_pkg::lc3b_reg    wr_dest;
  lc3b_isa_pkg::lc3b_word   wr_data;

  assign ir     = pop_instr;
  assign opcode = ir.op.opcode;

  // operate view.
  assign src1_value = regs[ir.op.src1];
  assign src2_value = regs[ir.op.field5[2:0]];
  assign imm5_sext  = {{11{ir.op.field5[4]}}, ir.op.field5};
  assign operand_b  = ir.op.imm_flag ? imm5_sext : src2_value;

  // memory and branch view, both offsets count in words.
  assign base_value   = regs[ir.mb.field9[8:6]];
  assign offset6_sext = {{9{ir.mb.field9[5]}}, ir.mb.field9[5:0], 1'b0};
  assign offset9_sext = {{6{ir.mb.field9[8]}}, ir.mb.field9, 1'b0};

  assign pop_ready = !mem_wait && !halted;
  assign pop_fire  = pop_valid && pop_ready;

  assign is_alu = opcode == lc3b_isa_pkg::op_add || opcode == lc3b_isa_pkg::op_and ||
                  opcode == lc3b_isa_pkg::op_not;
  assign is_mem = opcode == lc3b_isa_pkg::op_ldr || opcode == lc3b_isa_pkg::op_str;

  // A zero mask is never taken, so the all-zero word retires as a NOP.
  assign redirect    = pop_fire && opcode == lc3b_isa_pkg::op_br && |(ir.mb.field3 & nzp);
  assign redirect_pc = pop_pc + 16'd2 + offset9_sext;

  always_comb begin
    case (opcode)
      lc3b_isa_pkg::op_add: alu_result = src1_value + operand_b;
      lc3b_isa_pkg::op_and: alu_result = src1_value & operand_b;
      lc3b_isa_pkg::op_not: alu_result = ~src1_value;
      default:              alu_result = src1_value;  // not written back.
    endcase
  end

  // Register write port. Load data arrives in the response cycle, ALU results in the pop cycle.
  always_comb begin
    wr_en   = 1'b0;
    wr_dest = ir.op.dest;
    wr_data = alu_result;
    if (mem_wait) begin
      wr_en   = data_response && !write_enable;  // only loads write back.
      wr_dest = mem_dest;
      wr_data = mem_rdata;
    end else if (pop_fire) begin
      wr_en = is_alu;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
      nzp          <= lc3b_isa_pkg::nzp_z;
      mem_wait     <= 1'b0;
      data_request <= 1'b0;
      write_enable <= 1'b0;
      halted       <= 1'b0;
    end else begin
      if (wr_en) begin
        regs[wr_dest] <= wr_data;
        nzp           <= lc3b_isa_pkg::nzp_of(wr_data);  // every register write sets the code.
      end

      if (mem_wait) begin
        if (data_response) begin
          mem_wait     <= 1'b0;
          data_request <= 1'b0;
          write_enable <= 1'b0;
        end
      end else if (pop_fire) begin
        if (is_mem) begin
          mem_wait     <= 1'b1;
          data_request <= 1'b1;  // raised the cycle after the pop.
          write_enable <= opcode == lc3b_isa_pkg::op_str;
        end else if (opcode == lc3b_isa_pkg::op_trap) begin
          halted <= 1'b1;  // held until reset.
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop_fire && is_mem) begin
      mem_address <= base_value + offset6_sext;
      write_data  <= regs[ir.mb.field3];
      mem_dest    <= ir.mb.field3;
    end
  end

endmodule

`default_nettype wire

/* rtl/cpu_datapath.sv */
`default_nettype none

module cpu_datapath (
  input  logic                    clk,
  input  logic                    reset,
  input  lc3b_isa_pkg::lc3b_word  instr,
  input  logic                    instruction_response,
  input  lc3b_isa_pkg::lc3b_word  mem_rdata,
  input  logic                    data_response,
  output lc3b_isa_pkg::lc3b_word  instruction_address,
  output logic                    instruction_request,
  output lc3b_isa_pkg::lc3b_word  mem_address,
  output lc3b_isa_pkg::lc3b_word  write_data,
  output logic                    data_request,
  output logic                    write_enable,
  output logic                    halted
);

  logic                   push_valid;
  logic                   push_ready;
  lc3b_isa_pkg::lc3b_word push_pc;
  lc3b_isa_pkg::lc3b_word push_instr;
  logic                   queue_push_valid;
  logic                   fetch_push_ready;
  logic                   pop_valid;
  logic                   pop_ready;
  lc3b_isa_pkg::lc3b_word pop_pc;
  lc3b_isa_pkg::lc3b_word pop_instr;
  logic                   redirect;
  lc3b_isa_pkg::lc3b_word redirect_pc;

  // Once halted, the fetch unit keeps its held word and stops requesting.
  assign queue_push_valid = push_valid && !halted;
  assign fetch_push_ready = push_ready && !halted;

  fetch_unit fetch (
    .clk, .reset, .instruction_response, .instr,
    .push_ready (fetch_push_ready),
    .redirect, .redirect_pc,
    .instruction_request, .instruction_address,
    .push_valid, .push_pc, .push_instr
  );

  fetch_queue queue (
    .clk, .reset,
    .flush      (redirect),  // a taken branch drops all queued words.
    .push_valid (queue_push_valid),
    .push_pc, .push_instr, .pop_ready,
    .push_ready, .pop_valid, .pop_pc, .pop_instr
  );

  execute_unit execute (
    .clk, .reset, .pop_valid, .pop_pc, .pop_instr, .data_response, .mem_rdata,
    .pop_ready, .redirect, .redirect_pc,
    .data_request, .mem_address, .write_enable, .write_data, .halted
  );

endmodule

`default_nettype wire

/* bench/cpu_datapath_properties.sv */
`default_nettype none

module cpu_datapath_properties (
  input logic                   clk,
  input logic                   reset,
  input logic                   instruction_request,
  input lc3b_isa_pkg::lc3b_word instruction_address,
  input logic                   instruction_response,
  input logic                   data_request,
  input lc3b_isa_pkg::lc3b_word mem_address,
  input logic                   data_response,
  input logic                   write_enable,
  input logic                   halted
);
  timeunit 1ns;
  timeprecision 1ps;

  // an open fetch keeps its address until the response cycle.
  instr_request_held: assert property (@(posedge clk) disable iff (reset)
    instruction_request && !instruction_response
      |=> instruction_request && $stable(instruction_address))
    else $error("instruction_request dropped or its address moved before the response");

  data_request_held: assert property (@(posedge clk) disable iff (reset)
    data_request && !data_response |=> data_request && $stable(mem_address))
    else $error("data_request dropped or mem_address moved before data_response");

  write_within_request: assert property (@(posedge clk) disable iff (reset)
    write_enable |-> data_request)
    else $error("write_enable high without data_request");

  // after the halt only a fetch already on the port may finish.
  no_fetch_after_halt: assert property (@(posedge clk) disable iff (reset)
    halted && !instruction_request |=> !instruction_request)
    else $error("a new instruction_request rose while halted");

endmodule

`default_nettype wire

/* bench/tb_cpu_datapath.sv */
`default_nettype none

module tb_cpu_datapath;
  timeunit 1ns;
  timeprecision 1ps;

  typedef lc3b_isa_pkg::lc3b_word word_t;

  logic  clk;
  logic  reset;
  word_t instr;
  logic  instruction_response;
  word_t mem_rdata;
  logic  data_response;
  word_t instruction_address;
  logic  instruction_request;
  word_t mem_address;
  word_t write_data;
  logic  data_request;
  logic  write_enable;
  logic  halted;

  word_t rom [32];      // program words, fetched by instruction_address[5:1].
  word_t ram [64];      // data memory, indexed by mem_address[6:1].
  word_t ref_ram [64];  // memory image of the reference run.
  word_t exp_addr [$];  // store addresses in program order.
  word_t exp_data [$];
  int    seed = 32'h75381d62;
  int    instr_wait;
  int    data_wait;
  int    store_count;
  int    mismatches;
  int    failures;

  cpu_datapath uut (.*);

  bind cpu_datapath cpu_datapath_properties props (.*);

  // Executes the program on ref_ram by the ISA rules and records each store in order.
  function automatic void run_reference();
    word_t                   r [8];
    lc3b_isa_pkg::lc3b_nzp   cc;
    lc3b_isa_pkg::lc3b_instr ir;
    word_t                   pc;
    word_t                   operand;
    word_t                   addr;
    word_t                   value;
    logic                    writes;
    logic                    done;
    for (int i = 0; i < 8; i++) begin
      r[i] = '0;
    end
    cc   = 3'b010;  // zero code out of reset.
    pc   = 16'h0000;
    done = 1'b0;
    for (int step = 0; step < 200 && !done; step++) begin
      ir      = rom[pc[5:1]];
      pc      = pc + 16'd2;
      operand = ir.op.imm_flag ? {{11{ir.op.field5[4]}}, ir.op.field5} : r[ir.op.field5[2:0]];
      addr    = r[ir.mb.field9[8:6]] + {{9{ir.mb.field9[5]}}, ir.mb.field9[5:0], 1'b0};
      writes  = ir.op.opcode inside {lc3b_isa_pkg::op_add, lc3b_isa_pkg::op_and,
                                     lc3b_isa_pkg::op_not, lc3b_isa_pkg::op_ldr};
      case (ir.op.opcode)
        lc3b_isa_pkg::op_add: value = r[ir.op.src1] + operand;
        lc3b_isa_pkg::op_and: value = r[ir.op.src1] & operand;
        lc3b_isa_pkg::op_not: value = ~r[ir.op.src1];
        lc3b_isa_pkg::op_ldr: value = ref_ram[addr[6:1]];
        default:              value = '0;
      endcase
      if (writes) begin
        r[ir.op.dest] = value;  // the load's data register sits in the same bits.
        cc = value[15] ? 3'b100 : (value == 16'h0000 ? 3'b010 : 3'b001);
      end
      if (ir.op.opcode == lc3b_isa_pkg::op_str) begin
        ref_ram[addr[6:1]] = r[ir.mb.field3];
        exp_addr.push_back(addr);
        exp_data.push_back(r[ir.mb.field3]);
      end
      if (ir.op.opcode == lc3b_isa_pkg::op_br && (ir.mb.field3 & cc) != 3'b000) begin
        pc = pc + {{6{ir.mb.field9[8]}}, ir.mb.field9, 1'b0};
      end
      done = ir.op.opcode == lc3b_isa_pkg::op_trap;
    end
  endfunction

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Both memories answer 1 to 4 cycles after a request and hold the response for one cycle.
  always @(negedge clk) begin
    if (instruction_response) begin
      instruction_response = 1'b0;
    end else if (instruction_request) begin
      if (instr_wait == 0) begin
        instr_wait = 1 + ($random(seed) & 3);
      end
      instr_wait--;
      if (instr_wait == 0) begin
        instr                = rom[instruction_address[5:1]];
        instruction_response = 1'b1;
      end
    end
    if (data_response) begin
      data_response = 1'b0;
    end else if (data_request) begin
      if (data_wait == 0) begin
        data_wait = 1 + ($random(seed) & 3);
      end
      data_wait--;
      if (data_wait == 0) begin
        if (write_enable) begin
          ram[mem_address[6:1]] = write_data;
        end else begin
          mem_rdata = ram[mem_address[6:1]];
        end
        data_response = 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    if (data_response && write_enable) begin
      if (store_count < exp_addr.size()) begin
        assert (mem_address == exp_addr[store_count]) else begin
          mismatches++;
          $display("mismatch store_%0d address: expected %h, actual %h", store_count,
                   exp_addr[store_count], mem_address);
        end
        assert (write_data == exp_data[store_count]) else begin
          mismatches++;
          $display("mismatch store_%0d data: expected %h, actual %h", store_count,
                   exp_data[store_count], write_data);
        end
      end
      store_count++;  // extra stores show up in the final count check.
    end
  end

  initial begin
    reset                = 1'b1;
    instr                = '0;
    instruction_response = 1'b0;
    mem_rdata            = '0;
    data_response        = 1'b0;
    for (int i = 0; i < 64; i++) begin
      ram[i] = 16'($random(seed));
    end
    ref_ram = ram;
    rom = '{16'h13e5, 16'h15fd, 16'h1642, 16'h77d0,  // R1 is 5, R2 is -3, their sum is stored.
            16'h5866, 16'h79d1, 16'h9a7f, 16'h7bd2,  // AND immediate and NOT, each stored.
            16'h0801, 16'h73de, 16'h5cc4, 16'h0401,  // BRn jumps a store, then BRz is taken.
            16'h73df, 16'h0a01, 16'h75d3, 16'h1260,  // BRnp falls through to a store.
            16'h0c01, 16'h0000, 16'h0201, 16'h73de,  // BRnz falls through, BRp jumps a store.
            16'h63c2, 16'h65c3, 16'h1642, 16'h77d4,  // two loads and their sum stored.
            16'h5842, 16'h79d5, 16'h6bc4, 16'h0801,  // the sign of the third load steers BRn.
            16'h7bd6, 16'h7bd7, 16'hf025, 16'h0000};
    run_reference();
    repeat (8) begin
      @(negedge clk);
      assert (!instruction_request && !data_request && !write_enable) else begin
        failures++;
        $display("a request or write_enable was high during reset");
      end
    end
    reset = 1'b0;
    for (int t = 0; t < 4000 && !halted; t++) begin
      @(negedge clk);
    end
    assert (halted) else begin
      failures++;
      $display("timeout while waiting for halted, it stayed low for 4000 cycles");
    end
    for (int t = 0; t < 100 && instruction_request; t++) begin
      @(negedge clk);  // the last fetch still gets its response.
    end
    assert (!instruction_request) else begin
      failures++;
      $display("timeout while waiting for the last instruction response");
    end
    repeat (20) begin
      @(negedge clk);  // a halted core starts no fetch and no store.
    end
    assert (store_count == exp_addr.size()) else begin
      mismatches++;
      $display("mismatch store_count: expected %0d, actual %0d", exp_addr.size(), store_count);
    end
    for (int i = 0; i < 64; i++) begin
      assert (ram[i] == ref_ram[i]) else begin
        mismatches++;
        $display("mismatch final_ram[%0d]: expected %h, actual %h", i, ref_ram[i], ram[i]);
      end
    end
    $display("checks done with %0d mismatches and %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
rtl/lc3b_isa_pkg.sv
rtl/lc3b_core_pkg.sv
rtl/fetch_unit.sv
rtl/fetch_queue.sv
rtl/execute_unit.sv
rtl/cpu_datapath.sv
bench/cpu_datapath_properties.sv
bench/tb_cpu_datapath.sv

/* Makefile */
all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -f project.f \
	  --top-module tb_cpu_datapath -Mdir obj_dir -o tb_cpu_datapath

run: compile
	./obj_dir/tb_cpu_datapath > sim.log 2>&1; cat sim.log
	grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
